// ==== include/ofdm_demod_params.svh ====
`ifndef OFDM_DEMOD_PARAMS_SVH
`define OFDM_DEMOD_PARAMS_SVH

// transform size as a power of two
`define OFDM_NFFT 4
`define OFDM_FFT_LEN (1 << `OFDM_NFFT)

// width of one real or imaginary component
`define OFDM_SAMPLE_W 12

// twiddles are signed Q1.11
`define OFDM_TWIDDLE_W 12
`define OFDM_TWIDDLE_FRAC 11

// bandwidth part and SSB layout, in subcarriers and symbols
`define OFDM_BWP_LEN 12
`define OFDM_SSS_LEN 7
`define OFDM_SYMS_BTWN_SSB 8

// prefix length field, 0 to 7 samples
`define OFDM_CP_W 3

// two symbols can be in flight between the prefix remover and the mapper
`define OFDM_META_FIFO_DEPTH 4

// the window opens half a prefix early
`define OFDM_HALF_CP_ADVANCE 1

`endif

// ==== logic/cp_remover.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_demod_params.svh"

module cp_remover (
    input  wire                            clk_i,
    input  wire                            reset_ni,
    input  wire ofdm_demod_pkg::cplx_t     in_data_i,
    input  wire ofdm_demod_pkg::in_user_t  in_user_i,
    input  wire                            in_last_i,
    input  wire                            in_valid_i,
    output ofdm_demod_pkg::cplx_t          body_data_o,
    output logic                           body_valid_o,
    output logic                           body_last_o,
    output logic                           meta_push_o,
    output ofdm_demod_pkg::frame_meta_t    meta_o
);

    localparam ofdm_demod_pkg::bin_idx_t LAST_BODY = ofdm_demod_pkg::bin_idx_t'(`OFDM_FFT_LEN - 1);

    ofdm_demod_pkg::cp_state_e state;
    ofdm_demod_pkg::cp_len_t   skip_cnt;
    ofdm_demod_pkg::cp_len_t   skip_len_q;
    ofdm_demod_pkg::cp_len_t   skip_from_user;
    ofdm_demod_pkg::cp_len_t   skip_target;
    ofdm_demod_pkg::bin_idx_t  body_cnt;
    logic                      group_first;

    // the window opens half a prefix early, so only the rest of the prefix is skipped
    assign skip_from_user = in_user_i.cp_len -
        (`OFDM_HALF_CP_ADVANCE ? (in_user_i.cp_len >> 1) : ofdm_demod_pkg::cp_len_t'(0));

    // the first sample of a group sets the skip length for the whole prefix
    assign group_first = (state == ofdm_demod_pkg::SKIP_CP) && (skip_cnt == '0);
    assign skip_target = group_first ? skip_from_user : skip_len_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state        <= ofdm_demod_pkg::SKIP_CP;
            skip_cnt     <= '0;
            skip_len_q   <= '0;
            body_cnt     <= '0;
            body_valid_o <= 1'b0;
            body_last_o  <= 1'b0;
            meta_push_o  <= 1'b0;
        end else begin
            body_valid_o <= 1'b0;
            body_last_o  <= 1'b0;
            meta_push_o  <= 1'b0;
            if (in_valid_i) begin
                if (group_first) begin
                    skip_len_q <= skip_from_user;
                end
                case (state)
                    ofdm_demod_pkg::SKIP_CP: begin
                        if (skip_cnt == skip_target) begin
                            // this sample already belongs to the body
                            body_valid_o <= 1'b1;
                            body_cnt     <= ofdm_demod_pkg::bin_idx_t'(1);
                            skip_cnt     <= '0;
                            state        <= ofdm_demod_pkg::BODY;
                        end else begin
                            skip_cnt <= skip_cnt + 1'b1;
                        end
                    end
                    ofdm_demod_pkg::BODY: begin
                        body_valid_o <= 1'b1;
                        body_cnt     <= body_cnt + 1'b1;
                        if (body_cnt == LAST_BODY) begin
                            body_last_o <= 1'b1;
                            meta_push_o <= 1'b1;
                            state       <= in_last_i ? ofdm_demod_pkg::SKIP_CP
                                                     : ofdm_demod_pkg::SKIP_END;
                        end
                    end
                    default: begin
                        if (in_last_i) begin
                            state <= ofdm_demod_pkg::SKIP_CP;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            body_data_o <= in_data_i;
            meta_o      <= in_user_i.meta;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dft_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_demod_params.svh"

module dft_engine (
    input  wire                          clk_i,
    input  wire                          reset_ni,
    input  wire ofdm_demod_pkg::cplx_t   body_data_i,
    input  wire                          body_valid_i,
    input  wire                          body_last_i,
    output ofdm_demod_pkg::cplx_t        bin_data_o,
    output logic                         bin_valid_o,
    output logic                         bin_first_o
);

    localparam int LEN      = `OFDM_FFT_LEN;
    localparam int ACC_W    = `OFDM_SAMPLE_W + `OFDM_TWIDDLE_W + `OFDM_NFFT + 1;
    localparam int SCALE_SH = `OFDM_TWIDDLE_FRAC + `OFDM_NFFT;

    localparam ofdm_demod_pkg::bin_idx_t LAST_POS = ofdm_demod_pkg::bin_idx_t'(LEN - 1);

    typedef logic signed [`OFDM_TWIDDLE_W-1:0] tw_t;
    typedef logic signed [ACC_W-1:0]           acc_t;

    tw_t                      tw_re [LEN];
    tw_t                      tw_im [LEN];
    acc_t                     acc_re [LEN];
    acc_t                     acc_im [LEN];
    acc_t                     sum_re [LEN];
    acc_t                     sum_im [LEN];
    acc_t                     bank_re [LEN];
    acc_t                     bank_im [LEN];
    ofdm_demod_pkg::bin_idx_t tw_idx [LEN];
    ofdm_demod_pkg::bin_idx_t n_cnt;
    ofdm_demod_pkg::bin_idx_t pos;
    ofdm_demod_pkg::bin_idx_t rd_bin;
    logic                     draining;

    // W^m = exp(-j*2*pi*m/N), scaled to the twiddle fraction
    initial begin
        real ang;
        real scale;
        scale = real'((1 << `OFDM_TWIDDLE_FRAC) - 1);
        for (int m = 0; m < LEN; m++) begin
            ang      = 2.0 * 3.14159265358979 * real'(m) / real'(LEN);
            tw_re[m] = tw_t'(int'(scale * $cos(ang)));
            tw_im[m] = tw_t'(int'(-scale * $sin(ang)));
        end
    end

    // every bin k picks its twiddle for sample n, the index wraps modulo N
    always_comb begin
        for (int k = 0; k < LEN; k++) begin
            tw_idx[k] = ofdm_demod_pkg::bin_idx_t'(n_cnt * k);
            sum_re[k] = body_data_i.re * tw_re[tw_idx[k]] - body_data_i.im * tw_im[tw_idx[k]];
            sum_im[k] = body_data_i.re * tw_im[tw_idx[k]] + body_data_i.im * tw_re[tw_idx[k]];
            if (n_cnt != '0) begin
                sum_re[k] = sum_re[k] + acc_re[k];
                sum_im[k] = sum_im[k] + acc_im[k];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (body_valid_i) begin
            for (int k = 0; k < LEN; k++) begin
                acc_re[k] <= sum_re[k];
                acc_im[k] <= sum_im[k];
                if (body_last_i) begin
                    bank_re[k] <= sum_re[k];
                    bank_im[k] <= sum_im[k];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_cnt <= '0;
        end else if (body_valid_i) begin
            n_cnt <= body_last_i ? '0 : n_cnt + 1'b1;
        end
    end

    // a swap restarts the drain, the previous one has already finished by then
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            draining    <= 1'b0;
            pos         <= '0;
            bin_valid_o <= 1'b0;
            bin_first_o <= 1'b0;
        end else begin
            bin_valid_o <= draining;
            bin_first_o <= draining && (pos == '0);
            if (body_valid_i && body_last_i) begin
                draining <= 1'b1;
                pos      <= '0;
            end else if (draining) begin
                pos <= pos + 1'b1;
                if (pos == LAST_POS) begin
                    draining <= 1'b0;
                end
            end
        end
    end

    // centred order puts bin N/2 first
    assign rd_bin = pos + ofdm_demod_pkg::bin_idx_t'(LEN / 2);

    always_ff @(posedge clk_i) begin
        bin_data_o.re <= ofdm_demod_pkg::sample_t'(bank_re[rd_bin] >>> SCALE_SH);
        bin_data_o.im <= ofdm_demod_pkg::sample_t'(bank_im[rd_bin] >>> SCALE_SH);
    end

endmodule

`default_nettype wire

// ==== logic/meta_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_demod_params.svh"

module meta_fifo (
    input  wire                               clk_i,
    input  wire                               reset_ni,
    input  wire                               push_i,
    input  wire ofdm_demod_pkg::frame_meta_t  push_data_i,
    input  wire                               pop_i,
    output ofdm_demod_pkg::frame_meta_t       pop_data_o,
    output logic                              not_empty_o
);

    localparam int DEPTH = `OFDM_META_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    ofdm_demod_pkg::frame_meta_t mem [DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [PTR_W:0]              count;
    logic                        do_push;
    logic                        do_pop;

    assign do_push = push_i && (count != (PTR_W + 1)'(DEPTH));
    assign do_pop  = pop_i && (count != '0);

    // first word fall-through, the head entry is always on the output
    assign pop_data_o  = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ofdm_demod_pkg.sv ====
`default_nettype none

`include "ofdm_demod_params.svh"

package ofdm_demod_pkg;

    typedef logic signed [`OFDM_SAMPLE_W-1:0] sample_t;

    // used for time samples and for frequency bins alike
    typedef struct packed {
        sample_t im;
        sample_t re;
    } cplx_t;

    typedef logic [`OFDM_CP_W-1:0] cp_len_t;

    typedef struct packed {
        logic [9:0] sfn;
        logic [4:0] subframe;
        logic [3:0] symbol;
    } frame_meta_t;

    typedef struct packed {
        frame_meta_t meta;
        cp_len_t     cp_len;
    } in_user_t;

    typedef struct packed {
        frame_meta_t meta;
        logic        pbch_symbol;
    } out_user_t;

    typedef logic [`OFDM_NFFT-1:0] bin_idx_t;

    // symbol position within one SSB period
    typedef logic [2:0] sym_idx_t;

    typedef enum logic [1:0] {
        SKIP_CP,
        BODY,
        SKIP_END
    } cp_state_e;

endpackage

`default_nettype wire

// ==== logic/ofdm_demod_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ofdm_demod_top (
    input  wire                            clk_i,
    input  wire                            reset_ni,
    input  wire ofdm_demod_pkg::cplx_t     in_data_i,
    input  wire ofdm_demod_pkg::in_user_t  in_user_i,
    input  wire                            in_last_i,
    input  wire                            in_valid_i,
    output ofdm_demod_pkg::cplx_t          out_data_o,
    output ofdm_demod_pkg::out_user_t      out_user_o,
    output logic                           out_valid_o,
    output logic                           out_last_o,
    output logic                           pbch_valid_o,
    output logic                           sss_valid_o
);

    wire ofdm_demod_pkg::cplx_t       body_data;
    wire                              body_valid;
    wire                              body_last;
    wire                              push;
    wire ofdm_demod_pkg::frame_meta_t push_data;
    wire ofdm_demod_pkg::cplx_t       bin_data;
    wire                              bin_valid;
    wire                              bin_first;
    wire                              pop;
    wire ofdm_demod_pkg::frame_meta_t pop_data;

    cp_remover cp_remover_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .in_data_i    (in_data_i),
        .in_user_i    (in_user_i),
        .in_last_i    (in_last_i),
        .in_valid_i   (in_valid_i),
        .body_data_o  (body_data),
        .body_valid_o (body_valid),
        .body_last_o  (body_last),
        .meta_push_o  (push),
        .meta_o       (push_data)
    );

    // metadata bypasses the transform, the mapper pops it with the first bin
    meta_fifo meta_fifo_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .not_empty_o ()
    );

    dft_engine dft_engine_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .body_data_i  (body_data),
        .body_valid_i (body_valid),
        .body_last_i  (body_last),
        .bin_data_o   (bin_data),
        .bin_valid_o  (bin_valid),
        .bin_first_o  (bin_first)
    );

    subcarrier_mapper subcarrier_mapper_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .bin_data_i   (bin_data),
        .bin_valid_i  (bin_valid),
        .bin_first_i  (bin_first),
        .meta_i       (pop_data),
        .meta_pop_o   (pop),
        .out_data_o   (out_data_o),
        .out_user_o   (out_user_o),
        .out_valid_o  (out_valid_o),
        .out_last_o   (out_last_o),
        .pbch_valid_o (pbch_valid_o),
        .sss_valid_o  (sss_valid_o)
    );

endmodule

`default_nettype wire

// ==== logic/subcarrier_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_demod_params.svh"

module subcarrier_mapper (
    input  wire                               clk_i,
    input  wire                               reset_ni,
    input  wire ofdm_demod_pkg::cplx_t        bin_data_i,
    input  wire                               bin_valid_i,
    input  wire                               bin_first_i,
    input  wire ofdm_demod_pkg::frame_meta_t  meta_i,
    output logic                              meta_pop_o,
    output ofdm_demod_pkg::cplx_t             out_data_o,
    output ofdm_demod_pkg::out_user_t         out_user_o,
    output logic                              out_valid_o,
    output logic                              out_last_o,
    output logic                              pbch_valid_o,
    output logic                              sss_valid_o
);

    localparam int LEN = `OFDM_FFT_LEN;

    localparam ofdm_demod_pkg::bin_idx_t SC_FIRST =
        ofdm_demod_pkg::bin_idx_t'(LEN / 2 - `OFDM_BWP_LEN / 2);
    localparam ofdm_demod_pkg::bin_idx_t SC_LAST =
        ofdm_demod_pkg::bin_idx_t'(LEN / 2 - `OFDM_BWP_LEN / 2 + `OFDM_BWP_LEN - 1);
    localparam ofdm_demod_pkg::bin_idx_t SSS_FIRST =
        ofdm_demod_pkg::bin_idx_t'(LEN / 2 - (`OFDM_SSS_LEN + 1) / 2);
    localparam ofdm_demod_pkg::bin_idx_t SSS_LAST =
        ofdm_demod_pkg::bin_idx_t'(LEN / 2 - (`OFDM_SSS_LEN + 1) / 2 + `OFDM_SSS_LEN - 1);
    localparam ofdm_demod_pkg::bin_idx_t LAST_POS = ofdm_demod_pkg::bin_idx_t'(LEN - 1);
    localparam ofdm_demod_pkg::sym_idx_t LAST_SYM =
        ofdm_demod_pkg::sym_idx_t'(`OFDM_SYMS_BTWN_SSB - 1);

    ofdm_demod_pkg::bin_idx_t    pos_cnt;
    ofdm_demod_pkg::bin_idx_t    cur_pos;
    ofdm_demod_pkg::sym_idx_t    sym_idx;
    ofdm_demod_pkg::frame_meta_t meta_q;
    ofdm_demod_pkg::frame_meta_t cur_meta;
    logic                        in_bwp;
    logic                        in_sss;

    assign cur_pos = bin_first_i ? '0 : pos_cnt;
    assign in_bwp  = (cur_pos >= SC_FIRST) && (cur_pos <= SC_LAST);
    assign in_sss  = (cur_pos >= SSS_FIRST) && (cur_pos <= SSS_LAST);

    // the head of the FIFO belongs to the symbol that starts now
    assign meta_pop_o = bin_valid_i && bin_first_i;
    assign cur_meta   = meta_pop_o ? meta_i : meta_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pos_cnt      <= '0;
            sym_idx      <= '0;
            out_valid_o  <= 1'b0;
            out_last_o   <= 1'b0;
            pbch_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
        end else begin
            out_valid_o  <= bin_valid_i && in_bwp;
            out_last_o   <= bin_valid_i && (cur_pos == SC_LAST);
            pbch_valid_o <= bin_valid_i && in_bwp && (sym_idx == '0);
            sss_valid_o  <= bin_valid_i && in_sss && (sym_idx == 3'd1);
            if (bin_valid_i) begin
                pos_cnt <= cur_pos + 1'b1;
                if (cur_pos == LAST_POS) begin
                    sym_idx <= (sym_idx == LAST_SYM) ? '0 : sym_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (meta_pop_o) begin
            meta_q <= meta_i;
        end
        out_data_o             <= bin_data_i;
        out_user_o.meta        <= cur_meta;
        out_user_o.pbch_symbol <= (sym_idx == '0);
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module ofdm_demod_tb \
    -Mdir obj_dir

./obj_dir/Vofdm_demod_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== sim/ofdm_demod_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_demod_params.svh"

module ofdm_demod_tb;

    localparam int LEN          = `OFDM_FFT_LEN;
    localparam int SCALE_SHIFT  = `OFDM_TWIDDLE_FRAC + `OFDM_NFFT;
    localparam int SSB_PERIOD   = `OFDM_SYMS_BTWN_SSB;
    localparam int CARRIERS     = `OFDM_BWP_LEN;
    localparam int FIRST_POS    = 2;
    localparam int LAST_POS     = 13;
    localparam int SSS_FIRST    = 4;
    localparam int SSS_LAST     = 10;
    localparam int N_SYMS       = 40;
    localparam int MAX_GAP      = 3;
    localparam int MAX_GROUP    = 7 + LEN + 3;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 32;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_SYMS * (MAX_GROUP + MAX_GAP) + 200;
    localparam logic [31:0] SEED = 32'h62d197dd;

    logic                        clk_i;
    logic                        reset_ni;
    ofdm_demod_pkg::cplx_t       in_data_i;
    ofdm_demod_pkg::in_user_t    in_user_i;
    logic                        in_last_i;
    logic                        in_valid_i;
    ofdm_demod_pkg::cplx_t       out_data_o;
    ofdm_demod_pkg::out_user_t   out_user_o;
    logic                        out_valid_o;
    logic                        out_last_o;
    logic                        pbch_valid_o;
    logic                        sss_valid_o;

    ofdm_demod_pkg::cplx_t       exp_data_q [$];
    ofdm_demod_pkg::frame_meta_t exp_meta_q [$];
    ofdm_demod_pkg::cplx_t       exp_d;
    ofdm_demod_pkg::frame_meta_t exp_m;
    int tw_re [LEN];
    int tw_im [LEN];
    int win_re [LEN];
    int win_im [LEN];
    int carrier_idx;
    int sym_cnt;
    int cycle_cnt;
    int checks;
    int data_err;
    int count_err;
    int meta_err;
    int pbch_err;
    int sss_err;
    int idle_err;
    int total_err;
    int pos;
    logic first_ssb;
    logic sss_sym;

    ofdm_demod_top dut_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .in_data_i    (in_data_i),
        .in_user_i    (in_user_i),
        .in_last_i    (in_last_i),
        .in_valid_i   (in_valid_i),
        .out_data_o   (out_data_o),
        .out_user_o   (out_user_o),
        .out_valid_o  (out_valid_o),
        .out_last_o   (out_last_o),
        .pbch_valid_o (pbch_valid_o),
        .sss_valid_o  (sss_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic compare(input string sig, input logic [31:0] got, input logic [31:0] exp,
                           inout int errs);
        checks++;
        assert (got === exp) else begin
            $display("FAIL t=%0t %s got %h expected %h", $time, sig, got, exp);
            errs++;
        end
    endtask

    // twiddles rounded to the nearest integer, W^m = exp(-j*2*pi*m/16)
    task automatic build_twiddles();
        real ang;
        for (int m = 0; m < LEN; m++) begin
            ang = 2.0 * 3.14159265358979 * real'(m) / real'(LEN);
            tw_re[m] = $rtoi($floor(2047.0 * $cos(ang) + 0.5));
            tw_im[m] = $rtoi($floor(-2047.0 * $sin(ang) + 0.5));
        end
    endtask

    // direct DFT of the captured window, kept positions only, in centred order
    task automatic model_symbol(input ofdm_demod_pkg::frame_meta_t meta);
        int k;
        int m;
        int acc_re;
        int acc_im;
        ofdm_demod_pkg::cplx_t bin;
        for (int p = FIRST_POS; p <= LAST_POS; p++) begin
            k = (p + LEN / 2) % LEN;
            acc_re = 0;
            acc_im = 0;
            for (int n = 0; n < LEN; n++) begin
                m = (n * k) % LEN;
                acc_re += win_re[n] * tw_re[m] - win_im[n] * tw_im[m];
                acc_im += win_re[n] * tw_im[m] + win_im[n] * tw_re[m];
            end
            bin.re = ofdm_demod_pkg::sample_t'(acc_re >>> SCALE_SHIFT);
            bin.im = ofdm_demod_pkg::sample_t'(acc_im >>> SCALE_SHIFT);
            exp_data_q.push_back(bin);
        end
        exp_meta_q.push_back(meta);
    endtask

    task automatic send_symbol();
        int cp_len;
        int tail;
        int gap;
        int skip;
        int len;
        ofdm_demod_pkg::in_user_t user;
        ofdm_demod_pkg::cplx_t    smp;
        cp_len = $urandom % 8;
        tail   = $urandom % 4;
        gap    = $urandom % (MAX_GAP + 1);
        // the window opens half a prefix early
        skip   = cp_len - cp_len / 2;
        len    = cp_len + LEN + tail;
        user.meta.sfn      = 10'($urandom);
        user.meta.subframe = 5'($urandom);
        user.meta.symbol   = 4'($urandom);
        user.cp_len        = ofdm_demod_pkg::cp_len_t'(cp_len);
        repeat (gap) begin
            @(negedge clk_i);
            in_valid_i   = 1'b0;
            in_last_i    = 1'b0;
            in_data_i.re = ofdm_demod_pkg::sample_t'($urandom);
            in_data_i.im = ofdm_demod_pkg::sample_t'($urandom);
        end
        for (int i = 0; i < len; i++) begin
            smp.re = ofdm_demod_pkg::sample_t'($urandom);
            smp.im = ofdm_demod_pkg::sample_t'($urandom);
            if (i >= skip && i < skip + LEN) begin
                win_re[i - skip] = smp.re;
                win_im[i - skip] = smp.im;
            end
            @(negedge clk_i);
            in_data_i  = smp;
            in_user_i  = user;
            in_valid_i = 1'b1;
            in_last_i  = (i == len - 1);
        end
        model_symbol(user.meta);
    endtask

    task automatic report_test(input string name, input int errs);
        $display("test %-24s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    // outputs change on the rising edge, so they are read on the falling one
    always @(negedge clk_i) begin
        if (reset_ni) begin
            if (out_valid_o) begin
                if (exp_data_q.size() == 0) begin
                    $display("t=%0t carrier arrived with no symbol pending", $time);
                    idle_err++;
                end else begin
                    exp_d = exp_data_q.pop_front();
                    if (carrier_idx == 0) begin
                        exp_m = exp_meta_q.pop_front();
                    end
                    pos       = carrier_idx + FIRST_POS;
                    first_ssb = (sym_cnt % SSB_PERIOD) == 0;
                    sss_sym   = (sym_cnt % SSB_PERIOD) == 1;
                    compare("out_data_o.re", out_data_o.re, exp_d.re, data_err);
                    compare("out_data_o.im", out_data_o.im, exp_d.im, data_err);
                    compare("out_last_o", out_last_o, carrier_idx == CARRIERS - 1, count_err);
                    compare("out_user_o.meta", out_user_o.meta, exp_m, meta_err);
                    compare("pbch_valid_o", pbch_valid_o, first_ssb, pbch_err);
                    compare("out_user_o.pbch_symbol", out_user_o.pbch_symbol, first_ssb,
                            pbch_err);
                    compare("sss_valid_o", sss_valid_o,
                            sss_sym && pos >= SSS_FIRST && pos <= SSS_LAST, sss_err);
                    carrier_idx++;
                    if (carrier_idx == CARRIERS) begin
                        carrier_idx = 0;
                        sym_cnt++;
                    end
                end
            end else begin
                compare("out_last_o", out_last_o, 1'b0, idle_err);
                compare("pbch_valid_o", pbch_valid_o, 1'b0, idle_err);
                compare("sss_valid_o", sss_valid_o, 1'b0, idle_err);
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d carriers never arrived",
                 cycle_cnt, exp_data_q.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        checks      = 0;
        data_err    = 0;
        count_err   = 0;
        meta_err    = 0;
        pbch_err    = 0;
        sss_err     = 0;
        idle_err    = 0;
        carrier_idx = 0;
        sym_cnt     = 0;
        reset_ni    = 1'b0;
        in_data_i   = '0;
        in_user_i   = '0;
        in_last_i   = 1'b0;
        in_valid_i  = 1'b0;
        build_twiddles();
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_ni = 1'b1;

        for (int s = 0; s < N_SYMS; s++) begin
            send_symbol();
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
        in_last_i  = 1'b0;

        while (exp_data_q.size() != 0) begin
            @(negedge clk_i);
        end
        // any stray carrier in this window is caught by the monitor
        repeat (DRAIN_CYCLES) @(negedge clk_i);

        report_test("carrier data", data_err);
        report_test("carriers per symbol", count_err);
        report_test("symbol metadata", meta_err);
        report_test("pbch strobe", pbch_err);
        report_test("sss strobe", sss_err);
        report_test("idle outputs", idle_err);
        total_err = data_err + count_err + meta_err + pbch_err + sss_err + idle_err;
        $display("checks %0d, errors %0d", checks, total_err);
        if (total_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/ofdm_demod_pkg.sv
logic/cp_remover.sv
logic/meta_fifo.sv
logic/dft_engine.sv
logic/subcarrier_mapper.sv
logic/ofdm_demod_top.sv
sim/ofdm_demod_tb.sv
